//--- filelist.f
src/mini_rv_pkg.sv
src/io_delay_line.sv
src/instr_decoder.sv
src/alu_execute.sv
src/result_writeback.sv
src/axi_lite_master.sv
src/core_sequencer.sv
src/mini_rv_top.sv
verification/mini_rv_checker.sv
verification/mini_rv_tb.sv

//--- src/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
	input  mini_rv_pkg::alu_op_t alu_op,
	input  logic use_imm,
	input  logic is_branch,
	input  logic branch_ne,
	input  logic is_jal,
	input  mini_rv_pkg::xlen_t rs1_val,
	input  mini_rv_pkg::xlen_t rs2_val,
	input  mini_rv_pkg::xlen_t imm,
	input  mini_rv_pkg::addr_t pc,
	output mini_rv_pkg::xlen_t alu_result,
	output mini_rv_pkg::addr_t next_pc,
	output mini_rv_pkg::addr_t mem_addr,
	output mini_rv_pkg::xlen_t link_val
);
	import mini_rv_pkg::*;

	xlen_t operand_b;
	addr_t pc_plus4;
	addr_t target;
	logic taken;

	assign operand_b = use_imm ? imm : rs2_val;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_result = rs1_val + operand_b;
			ALU_SUB: alu_result = rs1_val - operand_b;
			ALU_AND: alu_result = rs1_val & operand_b;
			ALU_OR: alu_result = rs1_val | operand_b;
			ALU_XOR: alu_result = rs1_val ^ operand_b;
			ALU_PASS_B: alu_result = operand_b;
			default: alu_result = '0;
		endcase
	end

	// loads and stores both use rs1 plus the decoded offset
	assign mem_addr = rs1_val + imm;

	// ----------------------------------------------------------------------
	// next pc
	// ----------------------------------------------------------------------
	assign pc_plus4 = pc + 32'd4;
	// branch and jal offsets are both pc relative
	assign target = pc + imm;
	assign taken = is_branch && ((rs1_val == rs2_val) != branch_ne);
	assign next_pc = (is_jal || taken) ? target : pc_plus4;
	assign link_val = pc_plus4;

endmodule

//--- src/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic req_write,
	input  mini_rv_pkg::addr_t req_addr,
	input  mini_rv_pkg::xlen_t req_wdata,
	input  mini_rv_pkg::strb_t req_strb,
	output logic done,
	output mini_rv_pkg::xlen_t rdata,
	output logic awvalid,
	input  logic awready,
	output mini_rv_pkg::addr_t awaddr,
	output logic wvalid,
	input  logic wready,
	output mini_rv_pkg::xlen_t wdata,
	output mini_rv_pkg::strb_t wstrb,
	input  logic bvalid,
	output logic bready,
	output logic arvalid,
	input  logic arready,
	output mini_rv_pkg::addr_t araddr,
	input  logic rvalid,
	output logic rready,
	input  mini_rv_pkg::xlen_t axi_rdata
);
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_RESP = 2'd2;

	logic [1:0] state;
	logic aw_pending;
	logic w_pending;

	// still waiting on that channel after this edge
	assign aw_pending = awvalid && !awready;
	assign w_pending = wvalid && !wready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req) begin
						if (req_write) begin
							awvalid <= 1'b1;
							wvalid <= 1'b1;
							awaddr <= req_addr;
							wdata <= req_wdata;
							wstrb <= req_strb;
						end else begin
							arvalid <= 1'b1;
							araddr <= req_addr;
						end
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (arvalid) begin
						if (arready) begin
							arvalid <= 1'b0;
							rready <= 1'b1;
							state <= ST_RESP;
						end
					end else begin
						// aw and w may be accepted in either order
						if (awready) begin
							awvalid <= 1'b0;
						end
						if (wready) begin
							wvalid <= 1'b0;
						end
						if (!aw_pending && !w_pending) begin
							bready <= 1'b1;
							state <= ST_RESP;
						end
					end
				end
				ST_RESP: begin
					if (bready && bvalid) begin
						bready <= 1'b0;
						done <= 1'b1;
						state <= ST_IDLE;
					end
					if (rready && rvalid) begin
						rready <= 1'b0;
						rdata <= axi_rdata;
						done <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- src/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer #(
	parameter mini_rv_pkg::addr_t RESET_PC = '0
) (
	input  logic clk,
	input  logic rst,
	input  logic done,
	input  mini_rv_pkg::xlen_t rdata,
	input  logic illegal,
	input  mini_rv_pkg::mem_op_t mem_op,
	input  mini_rv_pkg::addr_t mem_addr,
	input  mini_rv_pkg::xlen_t rs2_val,
	input  mini_rv_pkg::addr_t next_pc,
	input  logic wb_valid,
	output logic req,
	output logic req_write,
	output mini_rv_pkg::addr_t req_addr,
	output mini_rv_pkg::xlen_t req_wdata,
	output mini_rv_pkg::strb_t req_strb,
	output mini_rv_pkg::instr_u instr,
	output mini_rv_pkg::addr_t pc,
	output logic wb_en,
	output logic wb_sel_load,
	output logic wb_sel_link,
	output mini_rv_pkg::xlen_t load_data,
	output logic trap
);
	import mini_rv_pkg::*;

	localparam logic [2:0] S_FETCH = 3'd0;
	localparam logic [2:0] S_FETCH_WAIT = 3'd1;
	localparam logic [2:0] S_EXEC = 3'd2;
	localparam logic [2:0] S_MEM = 3'd3;
	localparam logic [2:0] S_WB = 3'd4;
	localparam logic [2:0] S_TRAP = 3'd5;

	logic [2:0] state;

	assign wb_en = (state == S_WB) && wb_valid;
	assign wb_sel_load = (mem_op == MEM_LW);
	assign wb_sel_link = (instr.r_view.opcode == OPC_JAL);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_FETCH;
			pc <= RESET_PC;
			req <= 1'b0;
			trap <= 1'b0;
		end else begin
			req <= 1'b0;
			case (state)
				// only entered from reset, later fetches start in write-back
				S_FETCH: begin
					req <= 1'b1;
					req_write <= 1'b0;
					req_addr <= pc;
					state <= S_FETCH_WAIT;
				end
				S_FETCH_WAIT: begin
					if (done) begin
						instr <= rdata;
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					if (illegal) begin
						trap <= 1'b1;
						state <= S_TRAP;
					end else if (mem_op != MEM_NONE) begin
						req <= 1'b1;
						req_write <= (mem_op != MEM_LW);
						req_addr <= mem_addr;
						if (mem_op == MEM_SB) begin
							// byte goes to its lane, one strobe bit
							req_wdata <= xlen_t'(rs2_val[7:0]) << {mem_addr[1:0], 3'b000};
							req_strb <= 4'b0001 << mem_addr[1:0];
						end else begin
							req_wdata <= rs2_val;
							req_strb <= 4'b1111;
						end
						state <= S_MEM;
					end else begin
						state <= S_WB;
					end
				end
				S_MEM: begin
					if (done) begin
						load_data <= rdata;
						state <= S_WB;
					end
				end
				S_WB: begin
					pc <= next_pc;
					req <= 1'b1;
					req_write <= 1'b0;
					req_addr <= next_pc;
					state <= S_FETCH_WAIT;
				end
				// S_TRAP holds here until reset
				default: begin
					trap <= 1'b1;
					state <= S_TRAP;
				end
			endcase
		end
	end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  mini_rv_pkg::instr_u instr,
	output mini_rv_pkg::reg_idx_t rs1,
	output mini_rv_pkg::reg_idx_t rs2,
	output mini_rv_pkg::reg_idx_t rd,
	output mini_rv_pkg::xlen_t imm,
	output mini_rv_pkg::alu_op_t alu_op,
	output logic use_imm,
	output mini_rv_pkg::mem_op_t mem_op,
	output logic is_branch,
	output logic branch_ne,
	output logic is_jal,
	output logic wb_valid,
	output logic illegal
);
	import mini_rv_pkg::*;

	xlen_t imm_i;
	xlen_t imm_s;
	xlen_t imm_b;
	xlen_t imm_u;
	xlen_t imm_j;

	assign rs1 = instr.r_view.rs1;
	assign rs2 = instr.r_view.rs2;
	assign rd = instr.r_view.rd;

	// ----------------------------------------------------------------------
	// immediates
	// ----------------------------------------------------------------------
	assign imm_i = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rs2};
	assign imm_u = {instr.r_view.funct7, instr.r_view.rs2, instr.r_view.rs1,
		instr.r_view.funct3, 12'b0};
	assign imm_j = {{11{instr.r_view.funct7[6]}}, instr.r_view.funct7[6], instr.r_view.rs1,
		instr.r_view.funct3, instr.r_view.rs2[0], instr.r_view.funct7[5:0],
		instr.r_view.rs2[4:1], 1'b0};
	// S and B share the split layout
	assign imm_s = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
	assign imm_b = {{19{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi[6], instr.s_view.imm_lo[0],
		instr.s_view.imm_hi[5:0], instr.s_view.imm_lo[4:1], 1'b0};

	// ----------------------------------------------------------------------
	// control fields
	// ----------------------------------------------------------------------
	always_comb begin
		imm = imm_i;
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		mem_op = MEM_NONE;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jal = 1'b0;
		wb_valid = 1'b0;
		illegal = 1'b0;
		case (instr.r_view.opcode)
			OPC_OP: begin
				wb_valid = 1'b1;
				case ({instr.r_view.funct7, instr.r_view.funct3})
					{7'b0000000, 3'b000}: alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: alu_op = ALU_SUB;
					{7'b0000000, 3'b111}: alu_op = ALU_AND;
					{7'b0000000, 3'b110}: alu_op = ALU_OR;
					{7'b0000000, 3'b100}: alu_op = ALU_XOR;
					default: illegal = 1'b1;
				endcase
			end
			OPC_OPIMM: begin
				use_imm = 1'b1;
				wb_valid = 1'b1;
				illegal = (instr.r_view.funct3 != 3'b000);
			end
			OPC_LUI: begin
				imm = imm_u;
				alu_op = ALU_PASS_B;
				use_imm = 1'b1;
				wb_valid = 1'b1;
			end
			OPC_LOAD: begin
				mem_op = MEM_LW;
				wb_valid = 1'b1;
				illegal = (instr.r_view.funct3 != 3'b010);
			end
			OPC_STORE: begin
				imm = imm_s;
				case (instr.s_view.funct3)
					3'b010: mem_op = MEM_SW;
					3'b000: mem_op = MEM_SB;
					default: illegal = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				imm = imm_b;
				is_branch = 1'b1;
				branch_ne = instr.s_view.funct3[0];
				illegal = (instr.s_view.funct3[2:1] != 2'b00);
			end
			OPC_JAL: begin
				imm = imm_j;
				is_jal = 1'b1;
				wb_valid = 1'b1;
			end
			// ebreak; ecall and csr access are not supported either
			OPC_SYSTEM: illegal = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

endmodule

//--- src/io_delay_line.sv
`timescale 1ns/1ps

module io_delay_line #(
	parameter int WIDTH = 1,
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);
	logic [WIDTH-1:0] stage [DEPTH];

	always_ff @(posedge clk) begin
		stage[0] <= din;
		for (int i = 1; i < DEPTH; i++) begin
			stage[i] <= stage[i-1];
		end
	end

	assign dout = stage[DEPTH-1];

endmodule

//--- src/mini_rv_pkg.sv
package mini_rv_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0] strb_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LW,
		MEM_SW,
		MEM_SB
	} mem_op_t;

	// register format, also used for the I, U and J immediates
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} r_view_t;

	// store/branch format, immediate split around the source fields
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_view_t;

	typedef union packed {
		r_view_t r_view;
		s_view_t s_view;
	} instr_u;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

//--- src/mini_rv_top.sv
`timescale 1ns/1ps

module mini_rv_top #(
	parameter mini_rv_pkg::addr_t RESET_PC = '0,
	parameter int DELAY_STAGES = 4
) (
	input  logic clk,
	input  logic rst,
	output logic trap,
	output logic awvalid,
	output mini_rv_pkg::addr_t awaddr,
	input  logic awready,
	output logic wvalid,
	output mini_rv_pkg::xlen_t wdata,
	output mini_rv_pkg::strb_t wstrb,
	input  logic wready,
	input  logic bvalid,
	output logic bready,
	output logic arvalid,
	output mini_rv_pkg::addr_t araddr,
	input  logic arready,
	input  logic rvalid,
	input  mini_rv_pkg::xlen_t rdata,
	output logic rready
);
	import mini_rv_pkg::*;

	// core side of the pins
	logic core_rst;
	logic core_trap;
	logic core_awvalid;
	addr_t core_awaddr;
	logic core_awready;
	logic core_wvalid;
	xlen_t core_wdata;
	strb_t core_wstrb;
	logic core_wready;
	logic core_bvalid;
	logic core_bready;
	logic core_arvalid;
	addr_t core_araddr;
	logic core_arready;
	logic core_rvalid;
	xlen_t core_rdata;
	logic core_rready;

	// between the core blocks
	instr_u instr;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	xlen_t imm;
	alu_op_t alu_op;
	mem_op_t mem_op;
	logic use_imm;
	logic is_branch;
	logic branch_ne;
	logic is_jal;
	logic wb_valid;
	logic illegal;
	xlen_t rs1_val;
	xlen_t rs2_val;
	xlen_t alu_result;
	xlen_t link_val;
	xlen_t load_data;
	addr_t next_pc;
	addr_t mem_addr;
	addr_t pc;
	logic wb_en;
	logic wb_sel_load;
	logic wb_sel_link;
	logic req;
	logic req_write;
	addr_t req_addr;
	xlen_t req_wdata;
	strb_t req_strb;
	logic done;
	xlen_t bus_rdata;

	// ----------------------------------------------------------------------
	// registered pins
	// ----------------------------------------------------------------------
	io_delay_line #( 1, DELAY_STAGES) dl_rst     (clk, rst,          core_rst);
	io_delay_line #( 1, DELAY_STAGES) dl_trap    (clk, core_trap,    trap);
	io_delay_line #( 1, DELAY_STAGES) dl_awvalid (clk, core_awvalid, awvalid);
	io_delay_line #(32, DELAY_STAGES) dl_awaddr  (clk, core_awaddr,  awaddr);
	io_delay_line #( 1, DELAY_STAGES) dl_awready (clk, awready,      core_awready);
	io_delay_line #( 1, DELAY_STAGES) dl_wvalid  (clk, core_wvalid,  wvalid);
	io_delay_line #(32, DELAY_STAGES) dl_wdata   (clk, core_wdata,   wdata);
	io_delay_line #( 4, DELAY_STAGES) dl_wstrb   (clk, core_wstrb,   wstrb);
	io_delay_line #( 1, DELAY_STAGES) dl_wready  (clk, wready,       core_wready);
	io_delay_line #( 1, DELAY_STAGES) dl_bvalid  (clk, bvalid,       core_bvalid);
	io_delay_line #( 1, DELAY_STAGES) dl_bready  (clk, core_bready,  bready);
	io_delay_line #( 1, DELAY_STAGES) dl_arvalid (clk, core_arvalid, arvalid);
	io_delay_line #(32, DELAY_STAGES) dl_araddr  (clk, core_araddr,  araddr);
	io_delay_line #( 1, DELAY_STAGES) dl_arready (clk, arready,      core_arready);
	io_delay_line #( 1, DELAY_STAGES) dl_rvalid  (clk, rvalid,       core_rvalid);
	io_delay_line #(32, DELAY_STAGES) dl_rdata   (clk, rdata,        core_rdata);
	io_delay_line #( 1, DELAY_STAGES) dl_rready  (clk, core_rready,  rready);

	// ----------------------------------------------------------------------
	// core
	// ----------------------------------------------------------------------
	core_sequencer #(
		.RESET_PC(RESET_PC)
	) core_sequencer_inst (
		.clk, .rst(core_rst), .done, .rdata(bus_rdata),
		.illegal, .mem_op, .mem_addr, .rs2_val, .next_pc, .wb_valid,
		.req, .req_write, .req_addr, .req_wdata, .req_strb,
		.instr, .pc, .wb_en, .wb_sel_load, .wb_sel_link, .load_data,
		.trap(core_trap)
	);

	instr_decoder instr_decoder_inst (
		.instr, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm, .mem_op,
		.is_branch, .branch_ne, .is_jal, .wb_valid, .illegal
	);

	alu_execute alu_execute_inst (
		.alu_op, .use_imm, .is_branch, .branch_ne, .is_jal,
		.rs1_val, .rs2_val, .imm, .pc,
		.alu_result, .next_pc, .mem_addr, .link_val
	);

	result_writeback result_writeback_inst (
		.clk, .rst(core_rst), .rs1, .rs2, .rd,
		.wb_en, .wb_sel_load, .wb_sel_link,
		.alu_result, .link_val, .load_data, .rs1_val, .rs2_val
	);

	axi_lite_master axi_lite_master_inst (
		.clk, .rst(core_rst),
		.req, .req_write, .req_addr, .req_wdata, .req_strb,
		.done, .rdata(bus_rdata),
		.awvalid(core_awvalid), .awready(core_awready), .awaddr(core_awaddr),
		.wvalid(core_wvalid), .wready(core_wready),
		.wdata(core_wdata), .wstrb(core_wstrb),
		.bvalid(core_bvalid), .bready(core_bready),
		.arvalid(core_arvalid), .arready(core_arready), .araddr(core_araddr),
		.rvalid(core_rvalid), .rready(core_rready), .axi_rdata(core_rdata)
	);

endmodule

//--- src/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
	input  logic clk,
	input  logic rst,
	input  mini_rv_pkg::reg_idx_t rs1,
	input  mini_rv_pkg::reg_idx_t rs2,
	input  mini_rv_pkg::reg_idx_t rd,
	input  logic wb_en,
	input  logic wb_sel_load,
	input  logic wb_sel_link,
	input  mini_rv_pkg::xlen_t alu_result,
	input  mini_rv_pkg::xlen_t link_val,
	input  mini_rv_pkg::xlen_t load_data,
	output mini_rv_pkg::xlen_t rs1_val,
	output mini_rv_pkg::xlen_t rs2_val
);
	import mini_rv_pkg::*;

	// x0 has no storage
	xlen_t regs [1:31];
	xlen_t wb_data;

	always_comb begin
		if (wb_sel_load) begin
			wb_data = load_data;
		end else if (wb_sel_link) begin
			wb_data = link_val;
		end else begin
			wb_data = alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && rd != '0) begin
			regs[rd] <= wb_data;
		end
	end

	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verification/mini_rv_checker.sv
`timescale 1ns/1ps

module mini_rv_checker (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic awvalid,
	input  logic awready,
	input  mini_rv_pkg::addr_t awaddr,
	input  logic wvalid,
	input  logic wready,
	input  mini_rv_pkg::xlen_t wdata,
	input  mini_rv_pkg::strb_t wstrb,
	input  logic bready,
	input  logic arvalid,
	input  logic arready,
	input  mini_rv_pkg::addr_t araddr,
	input  logic rready
);
	// number of assertion failures so far
	int fail_count = 0;

	// ------------------------------------------------------------------
	// valid and payload held until ready
	// ------------------------------------------------------------------
	aw_hold: assert property (@(posedge clk) disable iff (rst !== 1'b0)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			fail_count++;
			$error("awvalid or awaddr changed before awready");
		end

	w_hold: assert property (@(posedge clk) disable iff (rst !== 1'b0)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else begin
			fail_count++;
			$error("wvalid or write data changed before wready");
		end

	ar_hold: assert property (@(posedge clk) disable iff (rst !== 1'b0)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			fail_count++;
			$error("arvalid or araddr changed before arready");
		end

	// a new request only reaches an idle master
	req_idle: assert property (@(posedge clk) disable iff (rst !== 1'b0)
		req |-> !(awvalid || wvalid || arvalid || bready || rready))
		else begin
			fail_count++;
			$error("request issued while a transfer was still open");
		end

endmodule

bind axi_lite_master mini_rv_checker checker_inst (
	.clk(clk), .rst(rst), .req(req),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
	.bready(bready),
	.arvalid(arvalid), .arready(arready), .araddr(araddr),
	.rready(rready)
);

//--- verification/mini_rv_tb.sv
`timescale 1ns/1ps

module mini_rv_tb;
	import mini_rv_pkg::*;

	localparam addr_t RESET_PC = 32'h0;
	localparam int DELAY_STAGES = 4;
	localparam int TIMEOUT = 200;
	localparam int RUN_LIMIT = 5000;

	localparam int PIN_ARVALID = 0;
	localparam int PIN_RREADY = 1;
	localparam int PIN_BREADY = 2;
	localparam int PIN_AWVALID = 3;
	localparam int PIN_WVALID = 4;
	localparam int PIN_TRAP = 5;

	logic clk;
	logic rst;
	logic trap;
	logic awvalid;
	addr_t awaddr;
	logic awready;
	logic wvalid;
	xlen_t wdata;
	strb_t wstrb;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	addr_t araddr;
	logic arready;
	logic rvalid;
	xlen_t rdata;
	logic rready;

	// memory model state
	xlen_t mem [256];
	logic [31:0] rng_state;
	logic rand_delay;
	int reads_done;
	addr_t first_araddr;
	addr_t logged_addr [$];
	xlen_t logged_data [$];
	strb_t logged_strb [$];

	mini_rv_top #(
		.RESET_PC(RESET_PC),
		.DELAY_STAGES(DELAY_STAGES)
	) mini_rv_top_inst (
		.clk(clk), .rst(rst), .trap(trap),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// failure reporting and compares
	// ------------------------------------------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string what, input addr_t exp_addr, input addr_t got_addr,
		input xlen_t exp_data, input xlen_t got_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			report_failure($sformatf("mismatch at %0t: %s expected %h/%h got %h/%h",
				$time, what, exp_addr, exp_data, got_addr, got_data));
		end
	endtask

	task automatic compare_strb(input string what, input strb_t exp_strb, input strb_t got_strb);
		if (got_strb !== exp_strb) begin
			report_failure($sformatf("mismatch at %0t: %s strobe expected %b got %b",
				$time, what, exp_strb, got_strb));
		end
	endtask

	task automatic compare_trap(input string what, input logic exp_trap, input logic got_trap);
		if (got_trap !== exp_trap) begin
			report_failure($sformatf("mismatch at %0t: %s trap expected %b got %b",
				$time, what, exp_trap, got_trap));
		end
	endtask

	// protocol assertions in the bound checker
	always @(posedge clk) begin
		if (mini_rv_top_inst.axi_lite_master_inst.checker_inst.fail_count != 0) begin
			report_failure("the bus checker flagged an AXI handshake violation");
		end
	end

	// ------------------------------------------------------------------
	// random ready delays
	// ------------------------------------------------------------------
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int ready_delay();
		if (rand_delay) begin
			return int'(next_random() % 4);
		end
		return 0;
	endfunction

	function automatic logic pin_level(input int sel);
		case (sel)
			PIN_ARVALID: return arvalid;
			PIN_RREADY: return rready;
			PIN_BREADY: return bready;
			PIN_AWVALID: return awvalid;
			PIN_WVALID: return wvalid;
			default: return trap;
		endcase
	endfunction

	task automatic wait_pin(input int sel, input logic level, input string what);
		int n;
		n = 0;
		@(posedge clk);
		while (pin_level(sel) !== level) begin
			n++;
			if (n > TIMEOUT) begin
				report_failure($sformatf("timed out at %0t waiting for %s", $time, what));
			end
			@(posedge clk);
		end
	endtask

	// ------------------------------------------------------------------
	// instruction encoders, RV32I formats
	// ------------------------------------------------------------------
	function automatic xlen_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic xlen_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic xlen_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic xlen_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic xlen_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	localparam xlen_t EBREAK = 32'h00100073;

	task automatic clear_memory();
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i * 32'h9E3779B9) ^ 32'h5A5A_0000;
		end
	endtask

	task automatic load_instr(input int index, input xlen_t word);
		mem[RESET_PC[9:2] + index] = word;
	endtask

	// ------------------------------------------------------------------
	// AXI-lite memory model, one transfer at a time
	// ------------------------------------------------------------------
	task automatic serve_read();
		addr_t addr;
		int d;
		addr = araddr;
		if (reads_done == 0) begin
			first_araddr = addr;
		end
		d = ready_delay();
		repeat (d) @(posedge clk);
		#1 arready = 1'b1;
		@(posedge clk);
		#1 arready = 1'b0;
		wait_pin(PIN_RREADY, 1'b1, "rready");
		d = ready_delay();
		repeat (d) @(posedge clk);
		#1 rvalid = 1'b1;
		rdata = mem[addr[9:2]];
		@(posedge clk);
		#1 rvalid = 1'b0;
		reads_done++;
		wait_pin(PIN_ARVALID, 1'b0, "arvalid to drop");
	endtask

	task automatic serve_write();
		addr_t addr;
		xlen_t data;
		strb_t strb;
		int da;
		int dw;
		int d;
		addr = awaddr;
		data = wdata;
		strb = wstrb;
		if (reads_done == 0) begin
			report_failure("a write was issued before the first fetch completed");
		end
		da = ready_delay();
		dw = ready_delay();
		// aw and w are accepted independently
		for (int c = 0; c <= ((da > dw) ? da : dw); c++) begin
			#1 awready = (c == da);
			wready = (c == dw);
			@(posedge clk);
		end
		#1 awready = 1'b0;
		wready = 1'b0;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				mem[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
			end
		end
		logged_addr.push_back(addr);
		logged_data.push_back(data);
		logged_strb.push_back(strb);
		wait_pin(PIN_BREADY, 1'b1, "bready");
		d = ready_delay();
		repeat (d) @(posedge clk);
		#1 bvalid = 1'b1;
		@(posedge clk);
		#1 bvalid = 1'b0;
		wait_pin(PIN_AWVALID, 1'b0, "awvalid to drop");
		wait_pin(PIN_WVALID, 1'b0, "wvalid to drop");
	endtask

	task automatic reset_dut();
		@(posedge clk);
		#1 rst = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		logged_addr.delete();
		logged_data.delete();
		logged_strb.delete();
		reads_done = 0;
		wait_pin(PIN_TRAP, 1'b0, "trap to clear after reset");
		if (arvalid !== 1'b0 || awvalid !== 1'b0 || wvalid !== 1'b0 ||
			bready !== 1'b0 || rready !== 1'b0) begin
			report_failure("bus outputs were not idle after reset");
		end
	endtask

	// serve the bus until the core traps
	task automatic run_program();
		int idle;
		int steps;
		idle = 0;
		steps = 0;
		while (trap !== 1'b1) begin
			@(posedge clk);
			steps++;
			if (steps > RUN_LIMIT) begin
				report_failure("program did not reach the trap within the step limit");
			end
			if (arvalid === 1'b1) begin
				serve_read();
				idle = 0;
			end else if (awvalid === 1'b1 && wvalid === 1'b1) begin
				serve_write();
				idle = 0;
			end else if (trap !== 1'b1) begin
				idle++;
				if (idle > TIMEOUT) begin
					report_failure("core stalled with no bus request and no trap");
				end
			end
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic arith_test(input string tag);
		xlen_t expv [8];
		clear_memory();
		load_instr(0, enc_i(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011));
		load_instr(1, {20'hABCDE, 5'd2, 7'b0110111});
		load_instr(2, enc_i(12'hFFB, 5'd2, 3'b000, 5'd3, 7'b0010011));
		load_instr(3, enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd4));
		load_instr(4, enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd5));
		load_instr(5, enc_r(7'h00, 5'd4, 5'd3, 3'b111, 5'd6));
		load_instr(6, enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd7));
		load_instr(7, enc_r(7'h00, 5'd1, 5'd3, 3'b100, 5'd8));
		for (int k = 0; k < 8; k++) begin
			load_instr(8 + k, enc_s(12'h200 + 12'(4 * k), 5'(k + 1), 5'd0, 3'b010));
		end
		load_instr(16, EBREAK);
		expv[0] = 32'h123;
		expv[1] = 32'hABCDE << 12;
		expv[2] = expv[1] + 32'hFFFF_FFFB;
		expv[3] = expv[0] + expv[2];
		expv[4] = expv[0] - expv[2];
		expv[5] = expv[2] & expv[3];
		expv[6] = expv[0] | expv[1];
		expv[7] = expv[2] ^ expv[0];
		reset_dut();
		run_program();
		compare_word({tag, " first fetch"}, RESET_PC, first_araddr, '0, '0);
		if (logged_addr.size() != 8) begin
			report_failure({tag, ": wrong number of stores"});
		end
		for (int k = 0; k < 8; k++) begin
			compare_word(tag, 32'h200 + 4 * k, logged_addr[k], expv[k], logged_data[k]);
			compare_strb(tag, 4'b1111, logged_strb[k]);
		end
	endtask

	task automatic load_store_test();
		xlen_t lane;
		clear_memory();
		mem[32'h300 >> 2] = 32'hCAFE_F00D;
		load_instr(0, enc_i(12'h300, 5'd0, 3'b010, 5'd1, 7'b0000011));
		load_instr(1, enc_s(12'h304, 5'd1, 5'd0, 3'b010));
		for (int k = 0; k < 4; k++) begin
			load_instr(2 + k, enc_i(12'(8'h11 * (k + 1)), 5'd0, 3'b000, 5'(k + 2), 7'b0010011));
			load_instr(6 + k, enc_s(12'h310 + 12'(k), 5'(k + 2), 5'd0, 3'b000));
		end
		load_instr(10, EBREAK);
		reset_dut();
		run_program();
		if (logged_addr.size() != 5) begin
			report_failure("load/store: wrong number of stores");
		end
		compare_word("load then store", 32'h304, logged_addr[0], 32'hCAFE_F00D, logged_data[0]);
		compare_strb("load then store", 4'b1111, logged_strb[0]);
		for (int k = 0; k < 4; k++) begin
			lane = (logged_data[k + 1] >> (8 * k)) & 32'hFF;
			compare_word("byte store", 32'h310 + k, logged_addr[k + 1], 8'h11 * (k + 1), lane);
			compare_strb("byte store", 4'b0001 << k, logged_strb[k + 1]);
		end
	endtask

	task automatic branch_test();
		clear_memory();
		load_instr(0, enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
		load_instr(1, enc_i(12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011));
		load_instr(2, enc_i(12'd7, 5'd0, 3'b000, 5'd3, 7'b0010011));
		load_instr(3, enc_b(13'd8, 5'd2, 5'd1, 3'b000));
		load_instr(4, enc_s(12'h380, 5'd1, 5'd0, 3'b010));
		load_instr(5, enc_b(13'd8, 5'd3, 5'd1, 3'b001));
		load_instr(6, enc_s(12'h384, 5'd1, 5'd0, 3'b010));
		load_instr(7, enc_b(13'd8, 5'd3, 5'd1, 3'b000));
		load_instr(8, enc_s(12'h388, 5'd3, 5'd0, 3'b010));
		load_instr(9, enc_b(13'd8, 5'd2, 5'd1, 3'b001));
		load_instr(10, enc_s(12'h38C, 5'd2, 5'd0, 3'b010));
		load_instr(11, enc_j(21'd8, 5'd5));
		load_instr(12, enc_s(12'h390, 5'd1, 5'd0, 3'b010));
		load_instr(13, enc_s(12'h394, 5'd5, 5'd0, 3'b010));
		load_instr(14, EBREAK);
		reset_dut();
		run_program();
		// only the not-taken paths and the link store remain
		if (logged_addr.size() != 3) begin
			report_failure("branch: wrong number of marker stores");
		end
		compare_word("beq not taken", 32'h388, logged_addr[0], 32'd7, logged_data[0]);
		compare_word("bne not taken", 32'h38C, logged_addr[1], 32'd5, logged_data[1]);
		compare_word("jal link", 32'h394, logged_addr[2], RESET_PC + 32'd44 + 32'd4,
			logged_data[2]);
	endtask

	task automatic trap_test();
		clear_memory();
		load_instr(0, enc_i(12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011));
		load_instr(1, EBREAK);
		load_instr(2, enc_s(12'h3F0, 5'd1, 5'd0, 3'b010));
		reset_dut();
		run_program();
		if (reads_done != 2 || logged_addr.size() != 0) begin
			report_failure("ebreak: unexpected bus traffic before the trap");
		end
		for (int c = 0; c < 40; c++) begin
			@(posedge clk);
			compare_trap("after ebreak", 1'b1, trap);
			if (arvalid === 1'b1 || awvalid === 1'b1 || wvalid === 1'b1) begin
				report_failure("a bus request was issued after the trap");
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rng_state = 32'd66;
		rand_delay = 1'b0;
		reads_done = 0;
		first_araddr = '0;
		arith_test("arith");
		load_store_test();
		branch_test();
		rand_delay = 1'b1;
		arith_test("arith random ready");
		rand_delay = 1'b0;
		trap_test();
		$display("Test completed successfully");
		$finish;
	end

endmodule
